//--- flist.f
pixel_shade_pkg.sv
hit_point_stage.sv
light_shade.sv
shade_accumulate.sv
pixel_shade.sv
tb_pixel_shade.sv

//--- hit_point_stage.sv
module hit_point_stage (
    input  logic                      clk_in,
    input  logic                      rst_in,
    input  pixel_shade_pkg::ray_in_t  req,
    input  logic                      req_valid,
    output pixel_shade_pkg::surface_t surf,
    output logic                      surf_valid
);
    import pixel_shade_pkg::*;

    // wide enough for head + ray * t without overflow
    typedef logic signed [COORD_W+T_W+1:0] hit_wide_t;

    // cycle 1 state
    vec3_t        hit_q;
    vec3_t        block_pos_q;
    block_color_t color_q;
    logic         hit_valid_q;

    // one axis of the hit point, truncated back to a coordinate
    function automatic coord_t hit_axis(coord_t head, coord_t ray, logic [T_W-1:0] t);
        hit_wide_t full;
        full = hit_wide_t'(head) + hit_wide_t'(ray) * hit_wide_t'(t);
        return full[COORD_W-1:0];
    endfunction

    //////////////////////////////
    // cycle 1: hit point
    //////////////////////////////

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            hit_q       <= '0;
            block_pos_q <= '0;
            color_q     <= BLUE;
            hit_valid_q <= 1'b0;
        end else begin
            hit_q.x     <= hit_axis(req.head.x, req.ray.x, req.t);
            hit_q.y     <= hit_axis(req.head.y, req.ray.y, req.t);
            hit_q.z     <= hit_axis(req.head.z, req.ray.z, req.t);
            block_pos_q <= req.block_pos;
            color_q     <= req.color;
            hit_valid_q <= req_valid;
        end
    end

    //////////////////////////////
    // cycle 2: surface normal
    //////////////////////////////

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            surf       <= '0;
            surf_valid <= 1'b0;
        end else begin
            surf.hit      <= hit_q;
            // not normalised, lights scale it down later
            surf.normal.x <= hit_q.x - block_pos_q.x;
            surf.normal.y <= hit_q.y - block_pos_q.y;
            surf.normal.z <= hit_q.z - block_pos_q.z;
            surf.color    <= color_q;
            surf_valid    <= hit_valid_q;
        end
    end

endmodule

//--- light_shade.sv
module light_shade #(
    parameter int LIGHT_IDX = 0
) (
    input  logic                      clk_in,
    input  logic                      rst_in,
    input  pixel_shade_pkg::surface_t surf,
    input  logic                      surf_valid,
    output pixel_shade_pkg::rgb_t     contrib,
    output logic                      contrib_valid
);
    import pixel_shade_pkg::*;

    // one bit more than a coordinate, light minus hit cannot wrap
    typedef logic signed [COORD_W:0] dist_c_t;

    typedef struct packed {
        dist_c_t x;
        dist_c_t y;
        dist_c_t z;
    } dist_t;

    // full product width plus carry for the three-term sum
    typedef logic signed [2*COORD_W+2:0] dot_t;
    typedef logic [CHAN_W+1:0]           weighted_t;

    // cycle 1 state
    dist_t        dist_q;
    vec3_t        normal_q;
    block_color_t color_q1;
    logic         valid_q1;

    // cycle 2 state
    chan_t        lambert_q;
    block_color_t color_q2;
    logic         valid_q2;

    dot_t  dot;
    dot_t  dot_shr;
    chan_t lambert_d;

    // lambert scaled by an intensity given in quarters
    function automatic chan_t weigh(chan_t lambert, logic [1:0] quarters);
        weighted_t scaled;
        scaled = weighted_t'(lambert) * weighted_t'(quarters);
        return scaled[CHAN_W+1:2];
    endfunction

    //////////////////////////////
    // cycle 1: light vector
    //////////////////////////////

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            dist_q   <= '0;
            normal_q <= '0;
            color_q1 <= BLUE;
            valid_q1 <= 1'b0;
        end else begin
            dist_q.x <= dist_c_t'(LIGHT_POS[LIGHT_IDX].x) - dist_c_t'(surf.hit.x);
            dist_q.y <= dist_c_t'(LIGHT_POS[LIGHT_IDX].y) - dist_c_t'(surf.hit.y);
            dist_q.z <= dist_c_t'(LIGHT_POS[LIGHT_IDX].z) - dist_c_t'(surf.hit.z);
            normal_q <= surf.normal;
            color_q1 <= surf.color;
            valid_q1 <= surf_valid;
        end
    end

    //////////////////////////////
    // cycle 2: lambert term
    //////////////////////////////

    always_comb begin
        dot = dot_t'(dist_q.x) * dot_t'(normal_q.x)
            + dot_t'(dist_q.y) * dot_t'(normal_q.y)
            + dot_t'(dist_q.z) * dot_t'(normal_q.z);
        dot_shr = dot >>> LAMBERT_SHIFT;
        // facing away gives nothing, too bright pins at full scale
        if (dot_shr[2*COORD_W+2]) begin
            lambert_d = '0;
        end else if (|dot_shr[2*COORD_W+1:CHAN_W]) begin
            lambert_d = '1;
        end else begin
            lambert_d = dot_shr[CHAN_W-1:0];
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            lambert_q <= '0;
            color_q2  <= BLUE;
            valid_q2  <= 1'b0;
        end else begin
            lambert_q <= lambert_d;
            color_q2  <= color_q1;
            valid_q2  <= valid_q1;
        end
    end

    //////////////////////////////
    // cycle 3: colour and material
    //////////////////////////////

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            contrib       <= '0;
            contrib_valid <= 1'b0;
        end else begin
            contrib.r     <= (color_q2 == RED) ? weigh(lambert_q, LIGHT_INTENSITY[LIGHT_IDX][0]) : '0;
            // neither material reflects green
            contrib.g     <= '0;
            contrib.b     <= (color_q2 == BLUE) ? weigh(lambert_q, LIGHT_INTENSITY[LIGHT_IDX][2]) : '0;
            contrib_valid <= valid_q2;
        end
    end

    // whole three-stage pipe keeps its strobe aligned
    a_contrib_latency: assert property (
        @(posedge clk_in) disable iff (rst_in)
        contrib_valid == $past(surf_valid, 3)
    );

endmodule

//--- pixel_shade.sv
module pixel_shade (
    input  logic                     clk_in,
    input  logic                     rst_in,
    input  pixel_shade_pkg::ray_in_t req,
    input  logic                     req_valid,
    output pixel_shade_pkg::rgb_t    pixel,
    output logic                     pixel_valid
);
    import pixel_shade_pkg::*;

    surface_t              surf;
    logic                  surf_valid;
    rgb_t                  contrib [NUM_LIGHTS];
    logic [NUM_LIGHTS-1:0] contrib_valid;

    //////////////////////////////
    // hit point and normal
    //////////////////////////////

    hit_point_stage i_hit_point_stage (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .req        (req),
        .req_valid  (req_valid),
        .surf       (surf),
        .surf_valid (surf_valid)
    );

    //////////////////////////////
    // one shader per light
    //////////////////////////////

    for (genvar i = 0; i < NUM_LIGHTS; i++) begin : g_light
        light_shade #(
            .LIGHT_IDX (i)
        ) i_light_shade (
            .clk_in        (clk_in),
            .rst_in        (rst_in),
            .surf          (surf),
            .surf_valid    (surf_valid),
            .contrib       (contrib[i]),
            .contrib_valid (contrib_valid[i])
        );
    end

    // sum of all lights
    shade_accumulate i_shade_accumulate (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .contrib       (contrib),
        .contrib_valid (contrib_valid),
        .pixel         (pixel),
        .pixel_valid   (pixel_valid)
    );

endmodule

//--- pixel_shade_pkg.sv
package pixel_shade_pkg;

    //////////////////////////////
    // widths and counts
    //////////////////////////////

    localparam int COORD_W       = 16;
    localparam int T_W           = 8;
    localparam int CHAN_W        = 16;
    localparam int NUM_LIGHTS    = 3;
    // stands in for normalising both vectors
    localparam int LAMBERT_SHIFT = 8;

    //////////////////////////////
    // types
    //////////////////////////////

    typedef logic signed [COORD_W-1:0] coord_t;
    typedef logic [CHAN_W-1:0]         chan_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } vec3_t;

    // material of the struck block
    typedef enum logic {
        BLUE,
        RED
    } block_color_t;

    // one ray hit as handed in by the ray marcher
    typedef struct packed {
        vec3_t            head;
        vec3_t            ray;
        logic [T_W-1:0]   t;
        vec3_t            block_pos;
        block_color_t     color;
    } ray_in_t;

    // hit point and unnormalised normal
    typedef struct packed {
        vec3_t        hit;
        vec3_t        normal;
        block_color_t color;
    } surface_t;

    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
    } rgb_t;

    //////////////////////////////
    // fixed scene lights
    //////////////////////////////

    localparam vec3_t LIGHT_POS [NUM_LIGHTS] = '{
        '{x: coord_t'(140), y: coord_t'(180), z: coord_t'(30)},
        '{x: coord_t'(180), y: coord_t'(180), z: coord_t'(10)},
        '{x: coord_t'(220), y: coord_t'(180), z: coord_t'(30)}
    };

    // r, g, b intensity in quarters
    localparam logic [1:0] LIGHT_INTENSITY [NUM_LIGHTS][3] = '{
        '{2'd1, 2'd2, 2'd1},
        '{2'd3, 2'd2, 2'd3},
        '{2'd1, 2'd2, 2'd1}
    };

endpackage

//--- run.sh
#!/bin/sh
# build and run the testbench, a nonzero status means failure
verilator --binary --assert --top-module tb_pixel_shade -f flist.f -o tb_pixel_shade \
    && ./obj_dir/tb_pixel_shade \
    || exit 1

//--- shade_accumulate.sv
module shade_accumulate (
    input  logic                                      clk_in,
    input  logic                                      rst_in,
    input  pixel_shade_pkg::rgb_t                     contrib [pixel_shade_pkg::NUM_LIGHTS],
    input  logic [pixel_shade_pkg::NUM_LIGHTS-1:0]    contrib_valid,
    output pixel_shade_pkg::rgb_t                     pixel,
    output logic                                      pixel_valid
);
    import pixel_shade_pkg::*;

    // room for the sum of every light at full scale
    typedef logic [CHAN_W+$clog2(NUM_LIGHTS)-1:0] sum_t;

    sum_t sum_r;
    sum_t sum_g;
    sum_t sum_b;

    function automatic chan_t saturate(sum_t s);
        if (|s[$bits(sum_t)-1:CHAN_W]) begin
            return '1;
        end
        return s[CHAN_W-1:0];
    endfunction

    //////////////////////////////
    // per channel sums
    //////////////////////////////

    always_comb begin
        sum_r = '0;
        sum_g = '0;
        sum_b = '0;
        for (int i = 0; i < NUM_LIGHTS; i++) begin
            sum_r = sum_r + sum_t'(contrib[i].r);
            sum_g = sum_g + sum_t'(contrib[i].g);
            sum_b = sum_b + sum_t'(contrib[i].b);
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            pixel       <= '0;
            pixel_valid <= 1'b0;
        end else begin
            pixel.r     <= saturate(sum_r);
            pixel.g     <= saturate(sum_g);
            pixel.b     <= saturate(sum_b);
            // a pixel is done once every light has reported
            pixel_valid <= &contrib_valid;
        end
    end

    // the light pipes run in lockstep
    a_lights_aligned: assert property (
        @(posedge clk_in) disable iff (rst_in)
        (&contrib_valid) || !(|contrib_valid)
    );

endmodule

//--- tb_pixel_shade.sv
module tb_pixel_shade;
    import pixel_shade_pkg::*;

    localparam int RESET_CYCLES = 5;
    localparam int IDLE_CYCLES  = 4;
    localparam int LATENCY      = 6;
    localparam int MARGIN       = 20;
    localparam int NUM_FIXED    = 6;
    localparam int NUM_RANDOM   = 16;
    localparam int NUM_ENTRIES  = NUM_FIXED + NUM_RANDOM;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + IDLE_CYCLES + NUM_ENTRIES + LATENCY + MARGIN;

    typedef struct {
        string   name;
        ray_in_t req;
    } stim_t;

    logic    clk_in;
    logic    rst_in;
    ray_in_t req;
    logic    req_valid;
    rgb_t    pixel;
    logic    pixel_valid;

    stim_t       stim_q [$];
    rgb_t        exp_pix_q [$];
    string       exp_name_q [$];
    int          req_cycle_q [$];
    int          cycle;
    int          checked;
    int unsigned lcg_state;

    pixel_shade i_pixel_shade (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .req         (req),
        .req_valid   (req_valid),
        .pixel       (pixel),
        .pixel_valid (pixel_valid)
    );

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic check_value(string name, longint expected, longint actual);
        if (expected != actual) begin
            $display("Fail %s expected %0d actual %0d", name, expected, actual);
            $display("Something failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic int rand_range(int lo, int hi);
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lo + int'((lcg_state >> 16) % unsigned'(hi - lo + 1));
    endfunction

    function automatic vec3_t vec(int x, int y, int z);
        vec3_t v;
        v.x = coord_t'(x);
        v.y = coord_t'(y);
        v.z = coord_t'(z);
        return v;
    endfunction

    function automatic longint axis(vec3_t v, int a);
        case (a)
            0:       return longint'(v.x);
            1:       return longint'(v.y);
            default: return longint'(v.z);
        endcase
    endfunction

    task automatic add_entry(string name, vec3_t head, vec3_t ray, int t, vec3_t bp,
                             block_color_t color);
        stim_t s;
        s.name          = name;
        s.req.head      = head;
        s.req.ray       = ray;
        s.req.t         = 8'(t);
        s.req.block_pos = bp;
        s.req.color     = color;
        stim_q.push_back(s);
    endtask

    // reference model from hit point through the saturating sum
    function automatic rgb_t expected_pixel(ray_in_t r);
        longint hit [3];
        longint nrm [3];
        longint dot;
        longint lam;
        longint sum_r;
        longint sum_b;
        rgb_t   px;
        sum_r = 0;
        sum_b = 0;
        for (int a = 0; a < 3; a++) begin
            hit[a] = longint'(coord_t'(axis(r.head, a) + axis(r.ray, a) * longint'(r.t)));
            nrm[a] = longint'(coord_t'(hit[a] - axis(r.block_pos, a)));
        end
        for (int l = 0; l < NUM_LIGHTS; l++) begin
            dot = 0;
            for (int a = 0; a < 3; a++) begin
                dot += (axis(LIGHT_POS[l], a) - hit[a]) * nrm[a];
            end
            lam = dot >>> LAMBERT_SHIFT;
            if (lam < 0) lam = 0;
            if (lam > 65535) lam = 65535;
            if (r.color == RED) begin
                sum_r += (lam * longint'(LIGHT_INTENSITY[l][0])) >>> 2;
            end else begin
                sum_b += (lam * longint'(LIGHT_INTENSITY[l][2])) >>> 2;
            end
        end
        px.r = (sum_r > 65535) ? 16'hffff : chan_t'(sum_r);
        px.g = '0;
        px.b = (sum_b > 65535) ? 16'hffff : chan_t'(sum_b);
        return px;
    endfunction

    //////////////////////////////
    // cycle count and timeout
    //////////////////////////////

    always @(posedge clk_in) begin
        cycle <= cycle + 1;
        if (cycle > TIMEOUT_CYCLES) begin
            $display("timeout: not every pixel came back in time");
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

    // sampled mid cycle, away from the driving edge
    always @(negedge clk_in) begin
        if (!rst_in && req_valid) begin
            req_cycle_q.push_back(cycle);
        end
        if (pixel_valid) begin
            if (exp_pix_q.size() == 0 || req_cycle_q.size() == 0) begin
                $display("pixel_valid came with no request outstanding");
                $display("Something failed");
                $fatal(1, "unexpected pixel");
            end else if (cycle - req_cycle_q[0] != LATENCY) begin
                $display("pixel for %s came %0d cycles after its request instead of %0d",
                         exp_name_q[0], cycle - req_cycle_q[0], LATENCY);
                $display("Something failed");
                $fatal(1, "wrong latency");
            end else begin
                check_value({exp_name_q[0], " r"}, longint'(exp_pix_q[0].r), longint'(pixel.r));
                check_value({exp_name_q[0], " g"}, longint'(exp_pix_q[0].g), longint'(pixel.g));
                check_value({exp_name_q[0], " b"}, longint'(exp_pix_q[0].b), longint'(pixel.b));
                void'(exp_pix_q.pop_front());
                void'(exp_name_q.pop_front());
                void'(req_cycle_q.pop_front());
                checked <= checked + 1;
            end
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    initial begin
        rst_in    <= 1'b1;
        req       <= '0;
        req_valid <= 1'b0;
        lcg_state = 32'd72;

        add_entry("red_front", vec(180, 100, 10), vec(0, 1, 0), 50, vec(180, 100, 10), RED);
        add_entry("blue_front", vec(150, 120, 20), vec(1, 1, 0), 20, vec(170, 90, 20), BLUE);
        add_entry("facing_away", vec(180, 100, 10), vec(0, 0, 0), 0, vec(180, 150, 10), RED);
        // long normal far below the lights so lambert and sum both clip
        add_entry("saturate_red", vec(180, -30000, 10), vec(0, 0, 0), 0,
                  vec(180, -32000, 10), RED);
        add_entry("saturate_blue", vec(180, -30000, 10), vec(0, 0, 0), 0,
                  vec(180, -32000, 10), BLUE);
        add_entry("neg_ray", vec(300, 300, 300), vec(-2, -1, -3), 100, vec(90, 190, -5), RED);
        // bounded so head + ray * t stays inside a coordinate
        for (int i = 0; i < NUM_RANDOM; i++) begin
            add_entry($sformatf("random_%0d", i),
                      vec(rand_range(-1000, 1000), rand_range(-1000, 1000),
                          rand_range(-1000, 1000)),
                      vec(rand_range(-15, 15), rand_range(-15, 15), rand_range(-15, 15)),
                      rand_range(0, 255),
                      vec(rand_range(-1000, 1000), rand_range(-1000, 1000),
                          rand_range(-1000, 1000)),
                      (rand_range(0, 1) == 1) ? RED : BLUE);
        end

        repeat (RESET_CYCLES) @(posedge clk_in);
        rst_in <= 1'b0;

        // nothing may come out before the first request
        repeat (IDLE_CYCLES) begin
            @(negedge clk_in);
            check_value("idle pixel_valid", 0, longint'(pixel_valid));
        end

        foreach (stim_q[i]) begin
            @(posedge clk_in);
            req       <= stim_q[i].req;
            req_valid <= 1'b1;
            exp_pix_q.push_back(expected_pixel(stim_q[i].req));
            exp_name_q.push_back(stim_q[i].name);
        end
        @(posedge clk_in);
        req       <= '0;
        req_valid <= 1'b0;

        while (checked < NUM_ENTRIES) @(posedge clk_in);
        // a stray extra pixel would still be caught here
        repeat (LATENCY + 2) @(posedge clk_in);

        $display("Everything OK");
        $finish;
    end

endmodule
